// ==== Bender.yml ====
package:
  name: alu

sources:
  - aluPkg.sv
  - aluDecode.sv
  - aluSimpleExec.sv
  - aluMultiplier.sv
  - aluDivider.sv
  - aluResult.sv
  - aluTop.sv
  - target: simulation
    files:
      - aluTb.sv

// ==== aluDecode.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDecode import aluPkg::*; #(
	parameter int dataWidth = 32
) (
	input logic finished,
	input logic rst,
	input logic start,
	input AluReq req,
	input logic busy,
	output logic execValid,
	output ExecCtrl ctrl
);

	// Only the low dataWidth bits of each operand take part
	localparam logic [operandBits-1:0] operandMask = operandBits'({dataWidth{1'b1}});

	logic accept;

	// Classify by bit fields so undefined codes fall out as UNIT_NONE
	function automatic ExecUnit classify(input logic [4:0] code);
		ExecUnit unit;
		unit = UNIT_NONE;
		case (code[4:3])
			// Shift group, arith and rotate together is undefined
			2'b11: if (!(code[2] && code[1])) unit = UNIT_SIMPLE;
			2'b01: if (code[2:1] == 2'b00) unit = code[0] ? UNIT_DIV : UNIT_MUL;
			2'b00: begin
				// Logic ops 000xx except 00000
				if (!code[2] && code[1:0] != 2'b00) unit = UNIT_SIMPLE;
				// Add group, negate needs the subtract flag too
				if (code[2] && code[1:0] != 2'b10) unit = UNIT_SIMPLE;
			end
			default: unit = UNIT_NONE;
		endcase
		return unit;
	endfunction

	assign accept = start && !busy;

	always_ff @(posedge finished) begin
		if (rst) begin
			execValid <= 1'b0;
		end else begin
			execValid <= accept;
		end
	end

	// Held until the next accepted start
	always_ff @(posedge finished) begin
		if (accept) begin
			ctrl.unit <= classify(req.op);
			ctrl.op <= req.op;
			ctrl.a <= req.a & operandMask;
			ctrl.b <= req.b & operandMask;
		end
	end

endmodule

`default_nettype wire

// ==== aluDivider.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluDivider import aluPkg::*; #(
	parameter int dataWidth = 32
) (
	input logic finished,
	input logic rst,
	input logic execValid,
	input ExecCtrl ctrl,
	output logic done,
	output AluResult value
);

	localparam int countWidth = $clog2(dataWidth);

	logic load;
	logic running;
	logic lastStep;
	logic [countWidth-1:0] stepCount;
	logic [dataWidth-1:0] divisor;
	logic [dataWidth-1:0] remainder;
	// Dividend shifts out the top while quotient bits enter the bottom
	logic [dataWidth-1:0] quotient;
	logic [dataWidth:0] shiftedRem;
	logic [dataWidth:0] trial;
	logic borrow;

	assign load = execValid && (ctrl.unit == UNIT_DIV);
	assign lastStep = running && (stepCount == countWidth'(dataWidth - 1));

	// Next dividend bit into the partial remainder, then trial subtract
	assign shiftedRem = {remainder, quotient[dataWidth-1]};
	assign trial = shiftedRem - {1'b0, divisor};
	assign borrow = trial[dataWidth];

	always_ff @(posedge finished) begin
		if (rst) begin
			running <= 1'b0;
			done <= 1'b0;
			stepCount <= '0;
		end else begin
			done <= lastStep;
			if (load) begin
				running <= 1'b1;
				stepCount <= '0;
			end else if (running) begin
				running <= !lastStep;
				stepCount <= stepCount + 1'b1;
			end
		end
	end

	always_ff @(posedge finished) begin
		if (load) begin
			divisor <= ctrl.b[dataWidth-1:0];
			remainder <= '0;
			quotient <= ctrl.a[dataWidth-1:0];
		end else if (running) begin
			// Restore on borrow, otherwise keep the difference
			if (borrow) begin
				remainder <= shiftedRem[dataWidth-1:0];
			end else begin
				remainder <= trial[dataWidth-1:0];
			end
			quotient <= {quotient[dataWidth-2:0], !borrow};
		end
	end

	// Divide by zero never borrows, so quotient is all ones and remainder is A
	assign value = AluResult'({remainder, quotient});

endmodule

`default_nettype wire

// ==== aluMultiplier.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluMultiplier import aluPkg::*; #(
	parameter int dataWidth = 32
) (
	input logic finished,
	input logic rst,
	input logic execValid,
	input ExecCtrl ctrl,
	output logic done,
	output AluResult value
);

	localparam int countWidth = $clog2(dataWidth);

	logic load;
	logic running;
	logic lastStep;
	logic [countWidth-1:0] stepCount;
	logic [2*dataWidth-1:0] mcand;
	logic [dataWidth-1:0] mplier;
	logic [2*dataWidth-1:0] product;

	assign load = execValid && (ctrl.unit == UNIT_MUL);
	assign lastStep = running && (stepCount == countWidth'(dataWidth - 1));

	// Step counter and done pulse
	always_ff @(posedge finished) begin
		if (rst) begin
			running <= 1'b0;
			done <= 1'b0;
			stepCount <= '0;
		end else begin
			done <= lastStep;
			if (load) begin
				running <= 1'b1;
				stepCount <= '0;
			end else if (running) begin
				running <= !lastStep;
				stepCount <= stepCount + 1'b1;
			end
		end
	end

	// Shift-add, one multiplier bit per cycle, LSB first
	always_ff @(posedge finished) begin
		if (load) begin
			mcand <= {{dataWidth{1'b0}}, ctrl.a[dataWidth-1:0]};
			mplier <= ctrl.b[dataWidth-1:0];
			product <= '0;
		end else if (running) begin
			if (mplier[0]) begin
				product <= product + mcand;
			end
			mcand <= mcand << 1;
			mplier <= mplier >> 1;
		end
	end

	assign value = AluResult'(product);

endmodule

`default_nettype wire

// ==== aluPkg.sv ====
`default_nettype none

package aluPkg;

	// Operand and result sizes of the request and result words
	localparam int operandBits = 32;
	localparam int resultWidth = 64;

	// Bit 0 is the subtract flag, bit 1 the negate flag
	// Shifts are 1 1 arith rotate right
	typedef enum logic [4:0] {
		OP_NOT  = 5'b00001,
		OP_AND  = 5'b00010,
		OP_OR   = 5'b00011,
		OP_ADD  = 5'b00100,
		OP_SUB  = 5'b00101,
		OP_NEG  = 5'b00111,
		OP_MUL  = 5'b01000,
		OP_DIV  = 5'b01001,
		OP_SHL  = 5'b11000,
		OP_SHR  = 5'b11001,
		OP_ROL  = 5'b11010,
		OP_ROR  = 5'b11011,
		OP_SHLA = 5'b11100,
		OP_SHRA = 5'b11101
	} AluOp;

	// Unit that finishes a request
	typedef enum logic [2:0] {
		UNIT_SIMPLE = 3'd0,
		UNIT_MUL    = 3'd1,
		UNIT_DIV    = 3'd2,
		UNIT_NONE   = 3'd3
	} ExecUnit;

	// Request as presented at the top level
	typedef struct packed {
		AluOp op;
		logic [operandBits-1:0] a;
		logic [operandBits-1:0] b;
	} AluReq;

	// Decoded request held for the execute stage
	typedef struct packed {
		ExecUnit unit;
		AluOp op;
		logic [operandBits-1:0] a;
		logic [operandBits-1:0] b;
	} ExecCtrl;

	// Quotient low, remainder high for DIV; full product for MUL
	typedef logic [resultWidth-1:0] AluResult;

endpackage

`default_nettype wire

// ==== aluResult.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluResult import aluPkg::*; #(
	parameter int dataWidth = 32
) (
	input logic finished,
	input logic rst,
	input logic start,
	input logic execValid,
	input ExecCtrl ctrl,
	input AluResult simpleValue,
	input logic mulDone,
	input logic divDone,
	input AluResult mulValue,
	input AluResult divValue,
	output AluResult out,
	output logic done,
	output logic busy
);

	localparam AluResult simpleMask = AluResult'({dataWidth{1'b1}});

	logic accept;
	logic simpleIssue;
	logic simplePending;
	logic finishing;

	assign accept = start && !busy;
	assign simpleIssue = execValid && (ctrl.unit == UNIT_SIMPLE || ctrl.unit == UNIT_NONE);
	assign finishing = simplePending || mulDone || divDone;

	always_ff @(posedge finished) begin
		if (rst) begin
			busy <= 1'b0;
			done <= 1'b0;
			simplePending <= 1'b0;
			out <= '0;
		end else begin
			// Single-cycle path gets a full cycle before capture, ctrl is still held
			simplePending <= simpleIssue;
			done <= finishing;
			if (simplePending) begin
				out <= (ctrl.unit == UNIT_NONE) ? '0 : (simpleValue & simpleMask);
			end else if (mulDone) begin
				out <= mulValue;
			end else if (divDone) begin
				out <= divValue;
			end
			if (finishing) begin
				busy <= 1'b0;
			end else if (accept) begin
				busy <= 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== aluSimpleExec.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluSimpleExec import aluPkg::*; #(
	parameter int dataWidth = 32
) (
	input ExecCtrl ctrl,
	output AluResult value
);

	localparam int shiftWidth = $clog2(dataWidth);

	logic [dataWidth-1:0] a;
	logic [dataWidth-1:0] b;
	logic subFlag;
	logic negFlag;
	logic [dataWidth-1:0] opA;
	logic [dataWidth-1:0] opB;
	logic [dataWidth-1:0] sum;
	logic arithBit;
	logic rotBit;
	logic rightBit;
	logic [shiftWidth-1:0] amount;
	logic [2*dataWidth-1:0] doubled;
	logic [2*dataWidth-1:0] rotated;
	logic [dataWidth-1:0] shifted;
	logic [dataWidth-1:0] res;

	assign a = ctrl.a[dataWidth-1:0];
	assign b = ctrl.b[dataWidth-1:0];

	// Flags straight from the opcode bits
	assign subFlag = ctrl.op[0];
	assign negFlag = ctrl.op[1];
	assign arithBit = ctrl.op[2];
	assign rotBit = ctrl.op[1];
	assign rightBit = ctrl.op[0];

	// NEG is 0 - A, so A moves to the subtrahend side
	assign opA = negFlag ? '0 : a;
	assign opB = negFlag ? a : b;
	assign sum = opA + (subFlag ? ~opB : opB) + dataWidth'(subFlag);

	assign amount = shiftWidth'(ctrl.b % dataWidth);
	assign doubled = {a, a};

	always_comb begin
		rotated = rightBit ? (doubled >> amount) : (doubled << amount);
		if (rotBit) begin
			shifted = rightBit ? rotated[dataWidth-1:0] : rotated[2*dataWidth-1:dataWidth];
		end else if (rightBit && arithBit) begin
			shifted = $signed(a) >>> amount;
		end else if (rightBit) begin
			shifted = a >> amount;
		end else begin
			// SHLA is the same as SHL
			shifted = a << amount;
		end
	end

	always_comb begin
		case (ctrl.op)
			OP_NOT: res = ~a;
			OP_AND: res = a & b;
			OP_OR: res = a | b;
			OP_ADD, OP_SUB, OP_NEG: res = sum;
			OP_SHL, OP_SHR, OP_ROL, OP_ROR, OP_SHLA, OP_SHRA: res = shifted;
			default: res = '0;
		endcase
	end

	// Upper half stays zero for one-cycle ops
	assign value = AluResult'(res);

endmodule

`default_nettype wire

// ==== aluTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTb import aluPkg::*; ();

	localparam int dataWidth = 32;
	localparam int randomCount = 40;

	typedef struct packed {
		logic [4:0] op;
		logic [31:0] a;
		logic [31:0] b;
		logic [63:0] expected;
		logic overlap;
	} TestVector;

	logic finished;
	logic rst;
	logic start;
	AluReq req;
	AluResult out;
	logic done;
	logic busy;

	TestVector vectors[$];
	int cycleCount = 0;
	int cycleLimit = 1000000;
	int unsigned seedValue;
	logic [63:0] lastOut;

	aluTop #(.dataWidth(dataWidth)) u_dut (
		.finished(finished),
		.rst(rst),
		.start(start),
		.req(req),
		.out(out),
		.done(done),
		.busy(busy)
	);

	always #50 finished = ~finished;

	always @(posedge finished) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: the run went past %0d clock cycles", cycleLimit);
			$display("TESTS FAILED");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	task automatic checkEqual(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
			$display("TESTS FAILED");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	task automatic addVector(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
			input logic [63:0] expected, input logic overlap);
		TestVector v;
		v.op = op;
		v.a = a;
		v.b = b;
		v.expected = expected;
		v.overlap = overlap;
		vectors.push_back(v);
	endtask

	// Reference behavior written from the opcode definitions
	function automatic logic [63:0] modelResult(input logic [4:0] op, input logic [31:0] a,
			input logic [31:0] b);
		logic [4:0] sh;
		logic [31:0] low;
		sh = b[4:0];
		low = '0;
		case (op)
			OP_NOT: low = ~a;
			OP_AND: low = a & b;
			OP_OR: low = a | b;
			OP_ADD: low = a + b;
			OP_SUB: low = a - b;
			OP_NEG: low = 32'h0 - a;
			OP_MUL: return {32'h0, a} * {32'h0, b};
			OP_DIV: begin
				if (b == 32'h0) return {a, 32'hFFFF_FFFF};
				return {a % b, a / b};
			end
			OP_SHL, OP_SHLA: low = a << sh;
			OP_SHR: low = a >> sh;
			OP_SHRA: low = $signed(a) >>> sh;
			OP_ROL: low = (sh == 0) ? a : ((a << sh) | (a >> (32 - sh)));
			OP_ROR: low = (sh == 0) ? a : ((a >> sh) | (a << (32 - sh)));
			default: low = '0;
		endcase
		return {32'h0, low};
	endfunction

	function automatic int expectedLatency(input logic [4:0] op);
		if (op == OP_MUL || op == OP_DIV) return dataWidth + 2;
		return 2;
	endfunction

	function automatic logic [4:0] pickRandomOp(input int unsigned idx);
		case (idx)
			0: return OP_ADD;
			1: return OP_SUB;
			2: return OP_MUL;
			3: return OP_DIV;
			4: return OP_SHL;
			5: return OP_SHR;
			6: return OP_ROL;
			7: return OP_ROR;
			8: return OP_SHLA;
			default: return OP_SHRA;
		endcase
	endfunction

	task automatic fillVectors();
		addVector(OP_NOT, 32'h0F0F_00FF, 32'h0, 64'h0000_0000_F0F0_FF00, 1'b0);
		addVector(OP_AND, 32'hFF00_FF00, 32'h0FF0_0FF0, 64'h0000_0000_0F00_0F00, 1'b0);
		addVector(OP_OR, 32'hFF00_FF00, 32'h0FF0_0FF0, 64'h0000_0000_FFF0_FFF0, 1'b0);
		addVector(OP_ADD, 32'd15, 32'd25, 64'h0000_0000_0000_0028, 1'b0);
		addVector(OP_ADD, 32'hFFFF_FFFF, 32'h1, 64'h0, 1'b0);
		addVector(OP_SUB, 32'd15, 32'd25, 64'h0000_0000_FFFF_FFF6, 1'b0);
		addVector(OP_NEG, 32'd15, 32'h1234, 64'h0000_0000_FFFF_FFF1, 1'b0);
		addVector(OP_MUL, 32'd7, 32'd6, 64'h0000_0000_0000_002A, 1'b0);
		addVector(OP_MUL, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'hFFFF_FFFE_0000_0001, 1'b0);
		addVector(OP_MUL, 32'h0001_0000, 32'h0001_0000, 64'h0000_0001_0000_0000, 1'b0);
		addVector(OP_DIV, 32'd25, 32'd7, 64'h0000_0004_0000_0003, 1'b0);
		addVector(OP_DIV, 32'd5, 32'd9, 64'h0000_0005_0000_0000, 1'b0);
		addVector(OP_DIV, 32'h1234_5678, 32'h0, 64'h1234_5678_FFFF_FFFF, 1'b0);
		addVector(OP_DIV, 32'hFFFF_FFFF, 32'h1, 64'h0000_0000_FFFF_FFFF, 1'b0);
		addVector(OP_SHL, 32'h8000_0001, 32'd33, 64'h0000_0000_0000_0002, 1'b0);
		addVector(OP_SHL, 32'h1234_5678, 32'd0, 64'h0000_0000_1234_5678, 1'b0);
		addVector(OP_SHR, 32'h8000_0000, 32'd31, 64'h0000_0000_0000_0001, 1'b0);
		addVector(OP_ROL, 32'h8000_0001, 32'd1, 64'h0000_0000_0000_0003, 1'b0);
		addVector(OP_ROR, 32'hA000_0005, 32'd2, 64'h0000_0000_6800_0001, 1'b0);
		addVector(OP_ROR, 32'h1234_5678, 32'd32, 64'h0000_0000_1234_5678, 1'b0);
		addVector(OP_SHLA, 32'h0000_0003, 32'd2, 64'h0000_0000_0000_000C, 1'b0);
		addVector(OP_SHRA, 32'h8000_0000, 32'd4, 64'h0000_0000_F800_0000, 1'b0);
		addVector(OP_SHRA, 32'hF000_0000, 32'd36, 64'h0000_0000_FF00_0000, 1'b0);
		// Undefined codes finish as zero on the short path
		addVector(5'b00000, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 64'h0, 1'b0);
		addVector(5'b11110, 32'hFFFF_FFFF, 32'd3, 64'h0, 1'b0);
		// A second start lands while these are in flight
		addVector(OP_ADD, 32'd1, 32'd2, 64'h0000_0000_0000_0003, 1'b1);
		addVector(OP_MUL, 32'd3, 32'd5, 64'h0000_0000_0000_000F, 1'b1);
	endtask

	// Starts at a falling edge, leaves at a falling edge
	task automatic runRequest(input logic [4:0] op, input logic [31:0] a, input logic [31:0] b,
			input logic [63:0] expected, input logic overlap);
		AluReq nextReq;
		AluReq otherReq;
		int latency;
		int wantLatency;
		string label;
		label = $sformatf("op %b a %h b %h", op, a, b);
		wantLatency = expectedLatency(op);
		nextReq.op = AluOp'(op);
		nextReq.a = a;
		nextReq.b = b;
		otherReq.op = OP_OR;
		otherReq.a = 32'hDEAD_BEEF;
		otherReq.b = 32'h0F0F_0F0F;
		checkEqual(busy, 1'b0, {label, " busy before start"});
		@(posedge finished);
		start <= 1'b1;
		req <= nextReq;
		// Accepting edge
		@(posedge finished);
		start <= 1'b0;
		latency = 0;
		while (done !== 1'b1 && latency < wantLatency + 4) begin
			@(posedge finished);
			latency++;
			if (overlap && latency == 1) begin
				start <= 1'b1;
				req <= otherReq;
			end else if (overlap && latency == 2) begin
				start <= 1'b0;
			end
			@(negedge finished);
			if (done !== 1'b1) begin
				checkEqual(busy, 1'b1, {label, " busy while in flight"});
				checkEqual(out, lastOut, {label, " out held while in flight"});
			end
		end
		checkEqual(latency, wantLatency, {label, " cycles to done"});
		checkEqual(out, expected, {label, " result"});
		checkEqual(busy, 1'b0, {label, " busy with done"});
		lastOut = out;
		@(posedge finished);
		@(negedge finished);
		checkEqual(done, 1'b0, {label, " done width"});
		checkEqual(out, lastOut, {label, " out held after done"});
	endtask

	initial begin
		logic [4:0] op;
		logic [31:0] a;
		logic [31:0] b;
		finished = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		req = '0;
		lastOut = '0;
		seedValue = 32'h4915_8433;
		void'($urandom(seedValue));
		fillVectors();
		cycleLimit = (vectors.size() + randomCount) * (dataWidth + 8) + 20;

		for (int i = 0; i < 5; i++) begin
			@(posedge finished);
			if (i == 4) begin
				rst <= 1'b0;
			end
			@(negedge finished);
			checkEqual(busy, 1'b0, "busy during reset");
			checkEqual(done, 1'b0, "done during reset");
			checkEqual(out, 64'h0, "out during reset");
		end

		foreach (vectors[i]) begin
			runRequest(vectors[i].op, vectors[i].a, vectors[i].b, vectors[i].expected,
				vectors[i].overlap);
		end

		for (int n = 0; n < randomCount; n++) begin
			op = pickRandomOp($urandom % 10);
			a = $urandom;
			b = $urandom;
			// Small divisors give quotients above one
			if (op == OP_DIV && b[0]) begin
				b = b >> 24;
			end
			runRequest(op, a, b, modelResult(op, a, b), 1'b0);
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== aluTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module aluTop import aluPkg::*; #(
	parameter int dataWidth = 32
) (
	input logic finished,
	input logic rst,
	input logic start,
	input AluReq req,
	output AluResult out,
	output logic done,
	output logic busy
);

	logic execValid;
	ExecCtrl ctrl;
	AluResult simpleValue;
	logic mulDone;
	logic divDone;
	AluResult mulValue;
	AluResult divValue;

	// Stage 1
	aluDecode #(.dataWidth(dataWidth)) u_decode (
		.finished(finished),
		.rst(rst),
		.start(start),
		.req(req),
		.busy(busy),
		.execValid(execValid),
		.ctrl(ctrl)
	);

	// Stage 2 units
	aluSimpleExec #(.dataWidth(dataWidth)) u_simple (
		.ctrl(ctrl),
		.value(simpleValue)
	);

	aluMultiplier #(.dataWidth(dataWidth)) u_mul (
		.finished(finished),
		.rst(rst),
		.execValid(execValid),
		.ctrl(ctrl),
		.done(mulDone),
		.value(mulValue)
	);

	aluDivider #(.dataWidth(dataWidth)) u_div (
		.finished(finished),
		.rst(rst),
		.execValid(execValid),
		.ctrl(ctrl),
		.done(divDone),
		.value(divValue)
	);

	// Stage 3, also owns busy
	aluResult #(.dataWidth(dataWidth)) u_result (
		.finished(finished),
		.rst(rst),
		.start(start),
		.execValid(execValid),
		.ctrl(ctrl),
		.simpleValue(simpleValue),
		.mulDone(mulDone),
		.divDone(divDone),
		.mulValue(mulValue),
		.divValue(divValue),
		.out(out),
		.done(done),
		.busy(busy)
	);

endmodule

`default_nettype wire

// ==== sim.f ====
aluPkg.sv
aluDecode.sv
aluSimpleExec.sv
aluMultiplier.sv
aluDivider.sv
aluResult.sv
aluTop.sv
aluTb.sv
